/* arcade_input.f */
+incdir+common
common/arcade_input_pkg.sv
design/game_select_regs.sv
design/input/key_matrix.sv
design/input/joy_router.sv
design/input/tank_stick.sv
design/player_port_mux.sv
design/arcade_input_top.sv
sim/arcade_input_asserts.sv
sim/arcade_input_checker.sv
sim/arcade_input_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the player input testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -f arcade_input.f \
	--top-module arcade_input_tb -Mdir "$BUILD" -o arcade_input_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"$BUILD/arcade_input_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Checks failed" "$LOG"; then
	exit 1
fi
exit 0

/* sim/arcade_input_tb.sv */
//####################################################################
// Player input testbench
// Clock, reset, LFSR stimulus on the falling edge and test sequence
//####################################################################
`timescale 1ns/100ps
`default_nettype none

`include "arcade_input_settings.svh"

module arcade_input_tb
	import arcade_input_pkg::*;
();

	localparam int ACK_TIMEOUT = 20; // Cycles allowed for one compare

	logic         clk_sys;
	logic         arst_n;
	logic         load_wr;
	logic [15:0]  load_index;
	game_type_t   load_data;
	key_event_t   key_event;
	joy_word_t    joy_0, joy_1, joy_2, joy_3;
	stick_sel_t   sel_warrior, sel_valkyrie, sel_wizard, sel_elf;
	logic         service;
	player_port_t player_1, player_2, player_3, player_4;
	sys_port_t    sys_port;

	logic [35:0]  exp_keys;  // Coins 35..32, then players 4..1 bytewise
	logic         exp_tank;
	logic         exp_4p;
	logic         check_req;
	logic         check_ack;
	logic         test_done;
	logic [3:0]   test_num;
	logic         timed_out;
	logic [31:0]  lfsr;
	int           err_count;
	int           check_count;

	// Up arrow, left ctrl, R, S, L, right shift, keypad 2, keypad 0
	logic [8:0] dungeon_code [8] = '{9'h175, 9'h014, 9'h02D, 9'h01B,
		9'h04B, 9'h059, 9'h072, 9'h070};
	int         dungeon_bit  [8] = '{7, 1, 15, 8, 20, 16, 30, 25};
	// Up, down, right, left, then the diagonals
	logic [3:0] stick_dir    [8] = '{4'b1000, 4'b0100, 4'b0001, 4'b0010,
		4'b1001, 4'b1010, 4'b0101, 4'b0110};

	arcade_input_top arcade_input_top_i (.*);

	arcade_input_checker checker_i (
		.clk_sys(clk_sys), .check_req(check_req), .test_done(test_done),
		.test_num(test_num), .exp_keys(exp_keys), .exp_tank(exp_tank), .exp_4p(exp_4p),
		.joys({joy_3, joy_2, joy_1, joy_0}),
		.sels({sel_elf, sel_wizard, sel_valkyrie, sel_warrior}), .service(service),
		.players({player_4, player_3, player_2, player_1}), .sys_port(sys_port),
		.check_ack(check_ack), .err_count(err_count), .check_count(check_count)
	);

	initial clk_sys = 1'b0;
	always #20 clk_sys = ~clk_sys; // 40 ns period

	// Fibonacci LFSR x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			val  = {val[30:0], lfsr[0]};
		end
		return val;
	endfunction

	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk_sys);
		end
	endtask

	// Settle three cycles, then one compare with a bounded wait for the ack
	task automatic check_ports();
		int guard;
		guard = 0;
		wait_cycles(3);
		if (!timed_out) begin
			check_req = 1'b1;
			while (!check_ack && guard < ACK_TIMEOUT) begin
				@(negedge clk_sys);
				guard++;
			end
			check_req = 1'b0;
			if (!check_ack) begin
				$display("Checker gave no acknowledge within %0d cycles", ACK_TIMEOUT);
				timed_out = 1'b1;
			end
		end
	endtask

	// Flip the toggle bit, idx -1 for an unmapped code
	task automatic hit_key(input logic [8:0] code, input logic down, input int idx);
		@(negedge clk_sys);
		key_event = {~key_event[10], down, code};
		if (idx >= 0) exp_keys[idx] = down;
	endtask

	task automatic load_game(input logic [15:0] index, input game_type_t code);
		@(negedge clk_sys);
		load_wr    = 1'b1;
		load_index = index;
		load_data  = code;
		@(negedge clk_sys);
		load_wr = 1'b0;
		if (index == `GAME_LOAD_INDEX) begin // Mode rules of the register
			exp_tank = (code == `GAME_TANK);
			exp_4p   = (code == `GAME_GAUNTLET) || (code == `GAME_GAUNTLET_2);
		end
	endtask

	task automatic random_sticks();
		@(negedge clk_sys);
		joy_0        = joy_word_t'(take_bits(10));
		joy_1        = joy_word_t'(take_bits(10));
		joy_2        = joy_word_t'(take_bits(10));
		joy_3        = joy_word_t'(take_bits(10));
		sel_warrior  = stick_sel_t'(take_bits(2));
		sel_valkyrie = stick_sel_t'(take_bits(2));
		sel_wizard   = stick_sel_t'(take_bits(2));
		sel_elf      = stick_sel_t'(take_bits(2));
	endtask

	task automatic idle_sticks();
		@(negedge clk_sys);
		joy_0 = '0;
		joy_1 = '0;
		joy_2 = '0;
		joy_3 = '0;
	endtask

	task automatic finish_test();
		@(negedge clk_sys);
		test_done = 1'b1;
		@(negedge clk_sys);
		test_done = 1'b0;
		test_num  = test_num + 4'd1;
	endtask

	initial begin
		lfsr       = 32'hd7b459f9;
		arst_n     = 1'b0;
		load_wr    = 1'b0;
		load_index = '0;
		load_data  = '0;
		key_event  = '0;
		joy_0 = '0;
		joy_1 = '0;
		joy_2 = '0;
		joy_3 = '0;
		sel_warrior  = '0;
		sel_valkyrie = '0;
		sel_wizard   = '0;
		sel_elf      = '0;
		service   = 1'b0;
		exp_keys  = '0;
		exp_tank  = 1'b0;
		exp_4p    = 1'b1; // Reset type is the four-player game
		check_req = 1'b0;
		test_done = 1'b0;
		test_num  = 4'd1;
		timed_out = 1'b0;
		wait_cycles(10);
		arst_n = 1'b1;

		//####################################################################
		// Reset state and dungeon keys
		//####################################################################
		check_ports();
		finish_test();

		for (int i = 0; i < 8; i++) hit_key(dungeon_code[i], 1'b1, dungeon_bit[i]);
		check_ports();
		hit_key(9'h029, 1'b1, -1); // Space, not in the map
		check_ports();
		@(negedge clk_sys);
		key_event = {key_event[10], 1'b0, 9'h175}; // Same toggle, so no event
		check_ports();
		for (int i = 0; i < 8; i++) hit_key(dungeon_code[i], 1'b0, dungeon_bit[i]);
		check_ports();
		finish_test();

		// Joystick routing, then straight through
		for (int i = 0; i < 8; i++) begin
			random_sticks();
			check_ports();
		end
		load_game(`GAME_LOAD_INDEX, `GAME_GAUNTLET_2P);
		for (int i = 0; i < 4; i++) begin
			random_sticks();
			check_ports();
		end
		idle_sticks();
		finish_test();

		//####################################################################
		// Load index and tank mode
		//####################################################################
		load_game(16'd2, `GAME_TANK); // Ignored
		hit_key(9'h023, 1'b1, 13);    // D is player 2 left here
		check_ports();
		hit_key(9'h023, 1'b0, 13);
		load_game(`GAME_LOAD_INDEX, `GAME_TANK);
		hit_key(9'h023, 1'b1, 7);     // D, right track back
		hit_key(9'h016, 1'b1, 16);    // Start one
		check_ports();
		hit_key(9'h023, 1'b0, 7);
		hit_key(9'h016, 1'b0, 16);
		check_ports();
		finish_test();

		for (int i = 0; i < 8; i++) begin
			@(negedge clk_sys);
			joy_0 = {6'b0, stick_dir[i]};
			joy_1 = {6'b0, stick_dir[(i + 1) % 8]};
			check_ports();
		end
		idle_sticks();
		finish_test();

		// Coins and service in both maps
		hit_key(9'h02E, 1'b1, 32);
		hit_key(9'h036, 1'b1, 33);
		joy_2   = 10'h100; // Stick coin bit
		service = 1'b1;
		check_ports();
		hit_key(9'h02E, 1'b0, 32);
		hit_key(9'h036, 1'b0, 33);
		joy_2   = '0;
		service = 1'b0;
		check_ports();
		load_game(`GAME_LOAD_INDEX, `GAME_GAUNTLET);
		hit_key(9'h03D, 1'b1, 34);
		hit_key(9'h03E, 1'b1, 35);
		joy_3 = 10'h100;
		check_ports();
		hit_key(9'h03D, 1'b0, 34);
		hit_key(9'h03E, 1'b0, 35);
		joy_3 = '0;
		check_ports();
		finish_test();

		$display("%0d compares, %0d errors", check_count, err_count);
		if (timed_out || err_count != 0) begin
			$display("Checks failed");
		end else begin
			$display("All checks passed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim/arcade_input_checker.sv */
//####################################################################
// Player input checker
// Reference model of the port rules, compares on request
//####################################################################
`timescale 1ns/100ps
`default_nettype none

module arcade_input_checker
	import arcade_input_pkg::*;
(
	input  wire logic        clk_sys,
	input  wire logic        check_req,  // Compare at the next rising edge
	input  wire logic        test_done,
	input  wire logic [3:0]  test_num,
	input  wire logic [35:0] exp_keys,   // Coins 35..32, players 4..1 bytewise
	input  wire logic        exp_tank,
	input  wire logic        exp_4p,
	input  wire logic [39:0] joys,       // Sticks 3..0
	input  wire logic [7:0]  sels,       // Elf, wizard, valkyrie, warrior
	input  wire logic        service,
	input  wire logic [31:0] players,    // Ports 4..1
	input  wire sys_port_t   sys_port,
	output logic             check_ack,
	output int               err_count,
	output int               check_count
);

	logic         ack_q = 1'b0;
	int           errs = 0;
	int           checks = 0;
	int           test_errs = 0;
	int           test_checks = 0;
	player_port_t exp_port;
	sys_port_t    exp_sys;

	assign check_ack   = ack_q;
	assign err_count   = errs;
	assign check_count = checks;

	// Stick that character k plays with
	function automatic joy_word_t route(input int k);
		int num;
		num = exp_4p ? (k + int'(sels[k*2 +: 2])) % 4 : k;
		return joys[num*10 +: 10];
	endfunction

	// Tracks from an up, down, left, right stick
	function automatic track_t tracks(input logic [3:0] s);
		logic lf, lb, rf, rb;
		lf = (s == 4'b1000) || (s == 4'b0001) || (s == 4'b1001);
		lb = (s == 4'b0100) || (s == 4'b0010) || (s == 4'b0101);
		rf = (s == 4'b1000) || (s == 4'b0010) || (s == 4'b1010);
		rb = (s == 4'b0100) || (s == 4'b0001) || (s == 4'b0110);
		return {rb, lb, rf, lf};
	endfunction

	// Expected port k, zero based, active low
	function automatic player_port_t port_ref(input int k);
		player_port_t keys;
		joy_word_t    j, j0, j1;
		keys = exp_keys[k*8 +: 8];
		j    = route(k);
		j0   = route(0);
		j1   = route(1);
		if (!exp_tank) begin
			return ~(keys | {j[3:0], j[7:4]}); // Directions high, buttons low
		end else if (k < 2) begin
			return ~(keys | {tracks(j[3:0]), j[7:4]});
		end else if (k == 2) begin
			return ~(keys | {6'b0, j1[9], j0[9]}); // Starts
		end
		return ~keys;
	endfunction

	function automatic sys_port_t sys_ref();
		sys_port_t s;
		joy_word_t j;
		s[4] = ~service;
		for (int k = 0; k < 4; k++) begin
			j        = route(k);
			s[3 - k] = ~(exp_keys[32 + k] | j[8]); // Coin k+1
		end
		return s;
	endfunction

	always @(posedge clk_sys) begin
		ack_q <= check_req;
		if (check_req && !ack_q) begin
			for (int k = 0; k < 4; k++) begin
				exp_port = port_ref(k);
				if (players[k*8 +: 8] !== exp_port) begin
					$display("error player_%0d is %h, expected %h", k + 1,
						players[k*8 +: 8], exp_port);
					test_errs++;
				end
			end
			exp_sys = sys_ref();
			if (sys_port !== exp_sys) begin
				$display("error sys_port is %h, expected %h", sys_port, exp_sys);
				test_errs++;
			end
			test_checks++;
		end
		if (test_done) begin // One line per finished test
			$display("test %0d finished: %0d compares, %0d errors", test_num,
				test_checks, test_errs);
			errs        = errs + test_errs;
			checks      = checks + test_checks;
			test_errs   = 0;
			test_checks = 0;
		end
	end

endmodule

`default_nettype wire

/* sim/arcade_input_asserts.sv */
//####################################################################
// Player input assertions
// Port invariants, bound to the top level
//####################################################################
`timescale 1ns/100ps
`default_nettype none

module arcade_input_asserts
	import arcade_input_pkg::*;
(
	input wire logic         clk_sys,
	input wire logic         arst_n,
	input wire logic         mode_tank,
	input wire logic         service,
	input wire joy_word_t    joy_0, joy_1, joy_2, joy_3,
	input wire player_port_t player_1, player_2, player_3, player_4,
	input wire sys_port_t    sys_port
);

	// Service is a plain inverter onto bit 4
	service_inverted: assert property (@(posedge clk_sys) sys_port[4] == !service)
		else $error("sys_port bit 4 does not follow service");

	// Left track never driven both ways
	left_track_one_way: assert property (@(posedge clk_sys) disable iff (!arst_n)
		mode_tank |-> (player_1[4] || player_1[6]))
		else $error("player_1 left track forward and back together");

	// Idle sticks right after reset release
	idle_after_reset: assert property (@(posedge clk_sys)
		($rose(arst_n) && {joy_0, joy_1, joy_2, joy_3} == '0)
		|=> ({player_1, player_2, player_3, player_4} == '1))
		else $error("player ports not idle after reset release");

endmodule

bind arcade_input_top arcade_input_asserts arcade_input_asserts_i (
	.clk_sys(clk_sys), .arst_n(arst_n), .mode_tank(mode_tank), .service(service),
	.joy_0(joy_0), .joy_1(joy_1), .joy_2(joy_2), .joy_3(joy_3),
	.player_1(player_1), .player_2(player_2), .player_3(player_3),
	.player_4(player_4), .sys_port(sys_port)
);

`default_nettype wire

/* design/arcade_input_top.sv */
//####################################################################
// Arcade player input
// Game select register, keyboard map, joystick routing, tank
// tracks and port assembly
//####################################################################
`timescale 1ns/100ps
`default_nettype none

`include "arcade_input_settings.svh"

module arcade_input_top
	import arcade_input_pkg::*;
(
	input  wire logic        clk_sys,
	input  wire logic        arst_n,
	input  wire logic        load_wr,
	input  wire logic [15:0] load_index,
	input  wire game_type_t  load_data,
	input  wire key_event_t  key_event,
	input  wire joy_word_t   joy_0,
	input  wire joy_word_t   joy_1,
	input  wire joy_word_t   joy_2,
	input  wire joy_word_t   joy_3,
	input  wire stick_sel_t  sel_warrior,
	input  wire stick_sel_t  sel_valkyrie,
	input  wire stick_sel_t  sel_wizard,
	input  wire stick_sel_t  sel_elf,
	input  wire logic        service,
	output player_port_t     player_1,
	output player_port_t     player_2,
	output player_port_t     player_3,
	output player_port_t     player_4,
	output sys_port_t        sys_port
);

	logic                    mode_tank;
	logic                    mode_4p;
	player_port_t            key_p1, key_p2, key_p3, key_p4;
	logic [`NUM_PLAYERS-1:0] key_coin;
	joy_word_t               route_0, route_1, route_2, route_3;
	track_t                  track_a, track_b;

	//####################################################################
	// Mode and keyboard
	//####################################################################
	game_select_regs game_select_regs_i (
		.clk_sys(clk_sys), .arst_n(arst_n),
		.load_wr(load_wr), .load_index(load_index), .load_data(load_data),
		.mode_tank(mode_tank), .mode_4p(mode_4p)
	);

	key_matrix key_matrix_i (
		.clk_sys(clk_sys), .arst_n(arst_n),
		.key_event(key_event), .mode_tank(mode_tank),
		.key_p1(key_p1), .key_p2(key_p2), .key_p3(key_p3), .key_p4(key_p4),
		.key_coin(key_coin)
	);

	//####################################################################
	// Sticks and ports
	//####################################################################
	joy_router joy_router_i (
		.joy_0(joy_0), .joy_1(joy_1), .joy_2(joy_2), .joy_3(joy_3),
		.sel_warrior(sel_warrior), .sel_valkyrie(sel_valkyrie),
		.sel_wizard(sel_wizard), .sel_elf(sel_elf), .mode_4p(mode_4p),
		.route_0(route_0), .route_1(route_1), .route_2(route_2), .route_3(route_3)
	);

	// Tracks for the two tank drivers
	tank_stick tank_stick_a (
		.clk_sys(clk_sys), .arst_n(arst_n), .stick(route_0[3:0]), .track(track_a)
	);

	tank_stick tank_stick_b (
		.clk_sys(clk_sys), .arst_n(arst_n), .stick(route_1[3:0]), .track(track_b)
	);

	player_port_mux player_port_mux_i (
		.mode_tank(mode_tank),
		.key_p1(key_p1), .key_p2(key_p2), .key_p3(key_p3), .key_p4(key_p4),
		.key_coin(key_coin),
		.route_0(route_0), .route_1(route_1), .route_2(route_2), .route_3(route_3),
		.track_a(track_a), .track_b(track_b), .service(service),
		.player_1(player_1), .player_2(player_2), .player_3(player_3),
		.player_4(player_4), .sys_port(sys_port)
	);

endmodule

`default_nettype wire

/* design/player_port_mux.sv */
//####################################################################
// Player port mux
// Merges keys, routed sticks and tracks into the active-low
// player ports and the system port
//####################################################################
`timescale 1ns/100ps
`default_nettype none

`include "arcade_input_settings.svh"

module player_port_mux
	import arcade_input_pkg::*;
(
	input  wire logic                    mode_tank,
	input  wire player_port_t            key_p1,
	input  wire player_port_t            key_p2,
	input  wire player_port_t            key_p3,
	input  wire player_port_t            key_p4,
	input  wire logic [`NUM_PLAYERS-1:0] key_coin,
	input  wire joy_word_t               route_0,
	input  wire joy_word_t               route_1,
	input  wire joy_word_t               route_2,
	input  wire joy_word_t               route_3,
	input  wire track_t                  track_a,
	input  wire track_t                  track_b,
	input  wire logic                    service,  // Active high
	output player_port_t                 player_1,
	output player_port_t                 player_2,
	output player_port_t                 player_3,
	output player_port_t                 player_4,
	output sys_port_t                    sys_port
);

	// Dungeon layout, directions high and buttons low
	function automatic player_port_t dungeon(input player_port_t keys, input joy_word_t joy);
		dungeon = ~(keys | {joy[3:0], joy[7:4]});
	endfunction

	always_comb begin
		if (mode_tank) begin
			player_1 = ~(key_p1 | {track_a, route_0[7:4]});
			player_2 = ~(key_p2 | {track_b, route_1[7:4]});
			player_3 = ~(key_p3 | {6'b0, route_1[9], route_0[9]}); // Starts
			player_4 = ~key_p4;
		end else begin
			player_1 = dungeon(key_p1, route_0);
			player_2 = dungeon(key_p2, route_1);
			player_3 = dungeon(key_p3, route_2);
			player_4 = dungeon(key_p4, route_3);
		end
	end

	// Service then coins 1 to 4
	assign sys_port = ~{service,
		key_coin[0] | route_0[8],
		key_coin[1] | route_1[8],
		key_coin[2] | route_2[8],
		key_coin[3] | route_3[8]};

endmodule

`default_nettype wire

/* design/input/tank_stick.sv */
//####################################################################
// Tank stick
// Registered eight-way stick to twin track conversion
//####################################################################
`timescale 1ns/100ps
`default_nettype none

module tank_stick
	import arcade_input_pkg::*;
(
	input  wire logic       clk_sys,
	input  wire logic       arst_n,
	input  wire logic [3:0] stick,  // Up, down, left, right
	output track_t          track   // R back, L back, R fwd, L fwd
);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			track <= '0;
		end else begin
			case (stick)
				4'b1000: track <= 4'b0011; // Up, both forward
				4'b0100: track <= 4'b1100; // Down, both back
				4'b0001: track <= 4'b1001; // Right spins clockwise
				4'b0010: track <= 4'b0110; // Left spins the other way
				4'b1001: track <= 4'b0001; // Up-right, left track only
				4'b1010: track <= 4'b0010; // Up-left
				4'b0101: track <= 4'b0100; // Down-right
				4'b0110: track <= 4'b1000; // Down-left
				default: track <= 4'b0000; // Idle or conflicting
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/input/joy_router.sv */
//####################################################################
// Joystick router
// Hands each dungeon character its chosen joystick in
// four-player games, otherwise passes the sticks through
//####################################################################
`timescale 1ns/100ps
`default_nettype none

module joy_router
	import arcade_input_pkg::*;
(
	input  wire joy_word_t  joy_0,
	input  wire joy_word_t  joy_1,
	input  wire joy_word_t  joy_2,
	input  wire joy_word_t  joy_3,
	input  wire stick_sel_t sel_warrior,
	input  wire stick_sel_t sel_valkyrie,
	input  wire stick_sel_t sel_wizard,
	input  wire stick_sel_t sel_elf,
	input  wire logic       mode_4p,
	output joy_word_t       route_0,
	output joy_word_t       route_1,
	output joy_word_t       route_2,
	output joy_word_t       route_3
);

	// Joystick number to word
	function automatic joy_word_t pick(input stick_sel_t num);
		case (num)
			2'd0:    pick = joy_0;
			2'd1:    pick = joy_1;
			2'd2:    pick = joy_2;
			default: pick = joy_3;
		endcase
	endfunction

	// Character k takes stick (k + sel) mod 4 as a two-bit sum
	always_comb begin
		if (mode_4p) begin
			route_0 = pick(stick_sel_t'(2'd0 + sel_warrior));
			route_1 = pick(stick_sel_t'(2'd1 + sel_valkyrie));
			route_2 = pick(stick_sel_t'(2'd2 + sel_wizard));
			route_3 = pick(stick_sel_t'(2'd3 + sel_elf));
		end else begin
			route_0 = joy_0; // Straight through
			route_1 = joy_1;
			route_2 = joy_2;
			route_3 = joy_3;
		end
	end

endmodule

`default_nettype wire

/* design/input/key_matrix.sv */
//####################################################################
// Keyboard key matrix
// Turns toggle-coded key events into held key and coin bits
// using the dungeon map or the tank map
//####################################################################
`timescale 1ns/100ps
`default_nettype none

`include "arcade_input_settings.svh"

module key_matrix
	import arcade_input_pkg::*;
(
	input  wire logic               clk_sys,
	input  wire logic               arst_n,
	input  wire key_event_t         key_event,
	input  wire logic               mode_tank,
	output player_port_t            key_p1,    // Active high
	output player_port_t            key_p2,
	output player_port_t            key_p3,
	output player_port_t            key_p4,
	output logic [`NUM_PLAYERS-1:0] key_coin   // Coin k on bit k-1
);

	logic       tog_q;     // Toggle bit of the last cycle
	logic       key_new;
	logic       pressed;
	logic [8:0] scan_code; // Bit 8 marks extended codes

	assign key_new   = key_event[10] ^ tog_q;
	assign pressed   = key_event[9];
	assign scan_code = key_event[8:0];

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			tog_q    <= 1'b0;
			key_p1   <= '0;
			key_p2   <= '0;
			key_p3   <= '0;
			key_p4   <= '0;
			key_coin <= '0;
		end else begin
			tog_q <= key_event[10];
			if (key_new && mode_tank) begin
				case (scan_code)
					9'h023: key_p1[7] <= pressed; // D  right back
					9'h01B: key_p1[6] <= pressed; // S  left back
					9'h024: key_p1[5] <= pressed; // E  right forward
					9'h01D: key_p1[4] <= pressed; // W  left forward
					9'h02D: key_p1[3] <= pressed; // R  right thumb
					9'h015: key_p1[2] <= pressed; // Q  left thumb
					9'h02B: key_p1[1] <= pressed; // F  right trigger
					9'h01C: key_p1[0] <= pressed; // A  left trigger
					9'h042: key_p2[7] <= pressed; // K
					9'h03B: key_p2[6] <= pressed; // J
					9'h043: key_p2[5] <= pressed; // I
					9'h03C: key_p2[4] <= pressed; // U
					9'h044: key_p2[3] <= pressed; // O
					9'h035: key_p2[2] <= pressed; // Y
					9'h04B: key_p2[1] <= pressed; // L
					9'h033: key_p2[0] <= pressed; // H
					9'h016: key_p3[0] <= pressed; // 1  start one
					9'h01E: key_p3[1] <= pressed; // 2  start two
					9'h02E: key_coin[0] <= pressed; // 5
					9'h036: key_coin[1] <= pressed; // 6
					default: ; // Unmapped
				endcase
			end else if (key_new) begin
				case (scan_code)
					// Player 1 on extended arrows
					9'h175: key_p1[7] <= pressed;
					9'h172: key_p1[6] <= pressed;
					9'h16B: key_p1[5] <= pressed;
					9'h174: key_p1[4] <= pressed;
					9'h014: key_p1[1] <= pressed; // Left ctrl
					9'h011: key_p1[0] <= pressed; // Left alt
					// Player 2 on R F D G
					9'h02D: key_p2[7] <= pressed;
					9'h02B: key_p2[6] <= pressed;
					9'h023: key_p2[5] <= pressed;
					9'h034: key_p2[4] <= pressed;
					9'h01C: key_p2[1] <= pressed; // A
					9'h01B: key_p2[0] <= pressed; // S
					// Player 3 on I K J L
					9'h043: key_p3[7] <= pressed;
					9'h042: key_p3[6] <= pressed;
					9'h03B: key_p3[5] <= pressed;
					9'h04B: key_p3[4] <= pressed;
					9'h114: key_p3[1] <= pressed; // Right ctrl
					9'h059: key_p3[0] <= pressed; // Right shift
					// Player 4 on the keypad
					9'h075: key_p4[7] <= pressed;
					9'h072: key_p4[6] <= pressed;
					9'h06B: key_p4[5] <= pressed;
					9'h074: key_p4[4] <= pressed;
					9'h070: key_p4[1] <= pressed; // Keypad 0
					9'h071: key_p4[0] <= pressed; // Keypad period
					9'h02E: key_coin[0] <= pressed; // Coins on 5 to 8
					9'h036: key_coin[1] <= pressed;
					9'h03D: key_coin[2] <= pressed;
					9'h03E: key_coin[3] <= pressed;
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* design/game_select_regs.sv */
//####################################################################
// Game select register
// Holds the loaded game type and decodes the input mode from it
//####################################################################
`timescale 1ns/100ps
`default_nettype none

`include "arcade_input_settings.svh"

module game_select_regs
	import arcade_input_pkg::*;
(
	input  wire logic        clk_sys,
	input  wire logic        arst_n,
	input  wire logic        load_wr,    // One-cycle strobe
	input  wire logic [15:0] load_index,
	input  wire game_type_t  load_data,
	output logic             mode_tank,  // Tank key map and tracks
	output logic             mode_4p     // Joystick routing active
);

	game_type_t game_type;

	// Only the game-type index writes, others are ignored
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			game_type <= `GAME_TYPE_RESET;
		end else if (load_wr && (load_index == `GAME_LOAD_INDEX)) begin
			game_type <= load_data;
		end
	end

	// Mode decode straight off the register
	assign mode_tank = (game_type == `GAME_TANK);
	assign mode_4p   = (game_type == `GAME_GAUNTLET) ||
		(game_type == `GAME_GAUNTLET_2);
	// Anything else is a two-player dungeon game

endmodule

`default_nettype wire

/* common/arcade_input_pkg.sv */
//####################################################################
// Player input types
// Vector types shared by the input logic and its testbench
//####################################################################
`default_nettype none

package arcade_input_pkg;

	typedef logic [7:0] game_type_t; // Game code

	// Keyboard event
	// Bit 10 toggles per event, bit 9 pressed, bit 8 extended code
	typedef logic [10:0] key_event_t;

	// Joystick word
	// Right 0, left 1, down 2, up 3, buttons 7..4, coin 8, start 9
	typedef logic [9:0] joy_word_t;

	typedef logic [1:0] stick_sel_t; // Joystick number offset per character

	// Active-low player port
	// Up 7, down 6, left 5, right 4, fire 1, magic 0
	typedef logic [7:0] player_port_t;

	// Active-low system port
	// Service 4, coins 1 to 4 on bits 3 down to 0
	typedef logic [4:0] sys_port_t;

	// Tank tracks of one stick
	// Right back 3, left back 2, right forward 1, left forward 0
	typedef logic [3:0] track_t;

endpackage

`default_nettype wire

/* common/arcade_input_settings.svh */
//####################################################################
// Player input settings
// Game-type codes, load index and player count for the input block
//####################################################################
`ifndef ARCADE_INPUT_SETTINGS_SVH
`define ARCADE_INPUT_SETTINGS_SVH

// Game codes as written by the loader
`define GAME_GAUNTLET      8'd104 // Four players
`define GAME_GAUNTLET_2    8'd106 // Four players, second release
`define GAME_GAUNTLET_2P   8'd107 // Two-player dungeon cabinet
`define GAME_TANK          8'd118 // Tank controls

// Type after reset
`define GAME_TYPE_RESET    `GAME_GAUNTLET

// Load index that addresses the game-type byte
`define GAME_LOAD_INDEX    16'd1

// Player ports on the cabinet
`define NUM_PLAYERS        4

`endif
